/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount     = 32;

    localparam logic [dataWidth-1:0] resetPc = '0;

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSw      = 6'b101011;
    localparam logic [5:0] opBeq     = 6'b000100;

    // SPECIAL funct field, instr[5:0]
    localparam logic [5:0] functAddu = 6'b100001;
    localparam logic [5:0] functSubu = 6'b100011;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluLui
    } aluOpT;

    typedef struct packed {
        aluOpT                   aluOp;
        logic                    useImm;
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        logic [regAddrWidth-1:0] dest;
    } ctrlT;

    typedef struct packed {
        logic                 valid;
        ctrlT                 ctrl;
        logic [dataWidth-1:0] operandA;
        logic [dataWidth-1:0] operandB;
        logic [dataWidth-1:0] imm;
        logic [dataWidth-1:0] storeData;
    } exPayloadT;

    typedef struct packed {
        logic                 valid;
        ctrlT                 ctrl;
        logic [dataWidth-1:0] aluResult;
        logic [dataWidth-1:0] storeData;
    } memPayloadT;

    // valid marks a register-writing instruction, ready a known value
    typedef struct packed {
        logic                    valid;
        logic                    ready;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    value;
    } fwdSrcT;

endpackage

`default_nettype wire

/* design/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddr1,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddr2,
    output logic [cpuPkg::dataWidth-1:0]    readData1,
    output logic [cpuPkg::dataWidth-1:0]    readData2,
    input  logic                            writeEnable,
    input  logic [cpuPkg::regAddrWidth-1:0] writeAddr,
    input  logic [cpuPkg::dataWidth-1:0]    writeData
);

    logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

    zeroRegister: assert property (@(posedge clk) disable iff (reset)
        (readAddr1 == '0 |-> readData1 == '0) and (readAddr2 == '0 |-> readData2 == '0))
        else $error("register zero read back nonzero");

endmodule

`default_nettype wire

/* design/operandForward.sv */
`timescale 1ns/1ps
`default_nettype none

module operandForward (
    input  logic [cpuPkg::regAddrWidth-1:0] request,
    input  logic [cpuPkg::dataWidth-1:0]    regValue,
    input  cpuPkg::fwdSrcT                  exSrc,
    input  cpuPkg::fwdSrcT                  memSrc,
    input  cpuPkg::fwdSrcT                  wbSrc,
    output logic [cpuPkg::dataWidth-1:0]    value,
    output logic                            notReady
);

    logic exHit;
    logic memHit;
    logic wbHit;

    // Register zero is constant, never forwarded
    assign exHit  = (request != '0) && exSrc.valid  && (exSrc.dest  == request);
    assign memHit = (request != '0) && memSrc.valid && (memSrc.dest == request);
    assign wbHit  = (request != '0) && wbSrc.valid  && (wbSrc.dest  == request);

    // Youngest producer wins
    always_comb begin
        value    = regValue;
        notReady = 1'b0;
        if (exHit) begin
            value    = exSrc.value;
            notReady = !exSrc.ready;
        end else if (memHit) begin
            value    = memSrc.value;
            notReady = !memSrc.ready;
        end else if (wbHit) begin
            value    = wbSrc.value;
            notReady = !wbSrc.ready;
        end
    end

endmodule

`default_nettype wire

/* design/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall,
    input  logic                         branchTaken,
    input  logic [cpuPkg::dataWidth-1:0] branchTarget,
    output logic [cpuPkg::dataWidth-1:0] pc
);

    logic [cpuPkg::dataWidth-1:0] nextPc;

    always_comb begin
        nextPc = pc + 32'd4;
        if (stall) begin
            nextPc = pc;
        end else if (branchTaken) begin
            // Delay slot is already being fetched this cycle
            nextPc = branchTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= cpuPkg::resetPc;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::dataWidth-1:0]    instr,
    input  logic [cpuPkg::dataWidth-1:0]    fetchPc,
    input  cpuPkg::fwdSrcT                  exSrc,
    input  cpuPkg::fwdSrcT                  memSrc,
    input  cpuPkg::fwdSrcT                  wbSrc,
    input  logic                            regWrite,
    input  logic [cpuPkg::regAddrWidth-1:0] regWriteAddr,
    input  logic [cpuPkg::dataWidth-1:0]    regWriteData,
    output logic                            stall,
    output logic                            branchTaken,
    output logic [cpuPkg::dataWidth-1:0]    branchTarget,
    output cpuPkg::exPayloadT               exOut
);

    logic                            decValid;
    logic [cpuPkg::dataWidth-1:0]    decInstr;
    logic [cpuPkg::dataWidth-1:0]    decPc;
    cpuPkg::ctrlT                    ctrl;
    logic [cpuPkg::dataWidth-1:0]    imm;
    logic [cpuPkg::regAddrWidth-1:0] readA;
    logic [cpuPkg::regAddrWidth-1:0] readB;
    logic                            isBeq;
    logic [cpuPkg::dataWidth-1:0]    rfA;
    logic [cpuPkg::dataWidth-1:0]    rfB;
    logic [cpuPkg::dataWidth-1:0]    valueA;
    logic [cpuPkg::dataWidth-1:0]    valueB;
    logic                            waitA;
    logic                            waitB;

    // Hold the fetched word while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            decInstr <= instr;
            decPc    <= fetchPc;
        end
        if (reset) begin
            decValid <= 1'b0;
        end else begin
            decValid <= 1'b1;
        end
    end

    // Unused operands read register zero so they never stall
    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = cpuPkg::aluAdd;
        imm        = {{16{decInstr[15]}}, decInstr[15:0]};
        readA      = '0;
        readB      = '0;
        isBeq      = 1'b0;
        if (decValid) begin
            case (decInstr[31:26])
                cpuPkg::opSpecial: begin
                    if (decInstr[5:0] == cpuPkg::functAddu ||
                        decInstr[5:0] == cpuPkg::functSubu) begin
                        ctrl.aluOp    = (decInstr[5:0] == cpuPkg::functSubu) ?
                                        cpuPkg::aluSub : cpuPkg::aluAdd;
                        ctrl.regWrite = 1'b1;
                        ctrl.dest     = decInstr[15:11];
                        readA         = decInstr[25:21];
                        readB         = decInstr[20:16];
                    end
                end
                cpuPkg::opOri, cpuPkg::opLui: begin
                    ctrl.aluOp    = (decInstr[31:26] == cpuPkg::opOri) ?
                                    cpuPkg::aluOr : cpuPkg::aluLui;
                    ctrl.useImm   = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.dest     = decInstr[20:16];
                    imm           = {16'h0000, decInstr[15:0]};
                    readA         = (decInstr[31:26] == cpuPkg::opOri) ? decInstr[25:21] : '0;
                end
                cpuPkg::opLw: begin
                    ctrl.useImm   = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.dest     = decInstr[20:16];
                    readA         = decInstr[25:21];
                end
                cpuPkg::opSw: begin
                    ctrl.useImm   = 1'b1;
                    ctrl.memWrite = 1'b1;
                    readA         = decInstr[25:21];
                    readB         = decInstr[20:16];
                end
                cpuPkg::opBeq: begin
                    isBeq = 1'b1;
                    readA = decInstr[25:21];
                    readB = decInstr[20:16];
                end
                default: begin
                end
            endcase
        end
    end

    registerFile regs (
        .clk         (clk),
        .reset       (reset),
        .readAddr1   (readA),
        .readAddr2   (readB),
        .readData1   (rfA),
        .readData2   (rfB),
        .writeEnable (regWrite),
        .writeAddr   (regWriteAddr),
        .writeData   (regWriteData)
    );

    operandForward fwdA (
        .request  (readA),
        .regValue (rfA),
        .exSrc    (exSrc),
        .memSrc   (memSrc),
        .wbSrc    (wbSrc),
        .value    (valueA),
        .notReady (waitA)
    );

    operandForward fwdB (
        .request  (readB),
        .regValue (rfB),
        .exSrc    (exSrc),
        .memSrc   (memSrc),
        .wbSrc    (wbSrc),
        .value    (valueB),
        .notReady (waitB)
    );

    assign stall        = waitA || waitB;
    assign branchTaken  = isBeq && !stall && (valueA == valueB);
    assign branchTarget = decPc + 32'd4 + {imm[29:0], 2'b00};

    always_comb begin
        exOut.valid     = decValid && !stall;
        exOut.ctrl      = ctrl;
        exOut.operandA  = valueA;
        exOut.operandB  = valueB;
        exOut.imm       = imm;
        exOut.storeData = valueB;
    end

    bubbleOnStall: assert property (@(posedge clk) disable iff (reset)
        stall |-> !exOut.valid)
        else $error("decode issued an instruction while stalled");

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic               clk,
    input  logic               reset,
    input  cpuPkg::exPayloadT  exIn,
    output cpuPkg::fwdSrcT     exSrc,
    output cpuPkg::memPayloadT memOut
);

    cpuPkg::exPayloadT            exReg;
    logic [cpuPkg::dataWidth-1:0] operandB;
    logic [cpuPkg::dataWidth-1:0] aluResult;

    always_ff @(posedge clk) begin
        exReg <= exIn;
        if (reset) begin
            exReg.valid <= 1'b0;
        end
    end

    // Loads and stores share the add for address generation
    assign operandB = exReg.ctrl.useImm ? exReg.imm : exReg.operandB;

    always_comb begin
        case (exReg.ctrl.aluOp)
            cpuPkg::aluSub: aluResult = exReg.operandA - operandB;
            cpuPkg::aluOr:  aluResult = exReg.operandA | operandB;
            cpuPkg::aluLui: aluResult = {operandB[15:0], 16'h0000};
            default:        aluResult = exReg.operandA + operandB;
        endcase
    end

    // Result lands in the memory register, too late for decode this cycle
    always_comb begin
        exSrc.valid = exReg.valid && exReg.ctrl.regWrite;
        exSrc.ready = 1'b0;
        exSrc.dest  = exReg.ctrl.dest;
        exSrc.value = aluResult;
    end

    always_comb begin
        memOut.valid     = exReg.valid;
        memOut.ctrl      = exReg.ctrl;
        memOut.aluResult = aluResult;
        memOut.storeData = exReg.storeData;
    end

endmodule

`default_nettype wire

/* design/memWbStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  logic                            clk,
    input  logic                            reset,
    input  cpuPkg::memPayloadT              memIn,
    input  logic [cpuPkg::dataWidth-1:0]    memReadData,
    output logic [cpuPkg::dataWidth-1:0]    memAddr,
    output logic [cpuPkg::dataWidth-1:0]    memWriteData,
    output logic                            memWrite,
    output logic                            memRead,
    output cpuPkg::fwdSrcT                  memSrc,
    output cpuPkg::fwdSrcT                  wbSrc,
    output logic                            regWrite,
    output logic [cpuPkg::regAddrWidth-1:0] regWriteAddr,
    output logic [cpuPkg::dataWidth-1:0]    regWriteData
);

    cpuPkg::memPayloadT memReg;
    cpuPkg::fwdSrcT     wbReg;

    always_ff @(posedge clk) begin
        memReg      <= memIn;
        wbReg.ready <= 1'b1;
        wbReg.dest  <= memReg.ctrl.dest;
        wbReg.value <= memReg.ctrl.memRead ? memReadData : memReg.aluResult;
        if (reset) begin
            memReg.valid <= 1'b0;
            wbReg.valid  <= 1'b0;
        end else begin
            wbReg.valid <= memReg.valid && memReg.ctrl.regWrite;
        end
    end

    assign memAddr      = memReg.aluResult;
    assign memWriteData = memReg.storeData;
    assign memWrite     = memReg.valid && memReg.ctrl.memWrite;
    assign memRead      = memReg.valid && memReg.ctrl.memRead;

    // Load data only arrives with the bus response
    always_comb begin
        memSrc.valid = memReg.valid && memReg.ctrl.regWrite;
        memSrc.ready = !memReg.ctrl.memRead;
        memSrc.dest  = memReg.ctrl.dest;
        memSrc.value = memReg.aluResult;
    end

    assign wbSrc        = wbReg;
    assign regWrite     = wbReg.valid;
    assign regWriteAddr = wbReg.dest;
    assign regWriteData = wbReg.value;

    busExclusive: assert property (@(posedge clk) disable iff (reset)
        !(memWrite && memRead))
        else $error("memWrite and memRead high together");

endmodule

`default_nettype wire

/* design/pipelineCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module pipelineCpu (
    input  logic                         clk,
    input  logic                         reset,
    output logic [cpuPkg::dataWidth-1:0] instrAddr,
    input  logic [cpuPkg::dataWidth-1:0] instr,
    output logic [cpuPkg::dataWidth-1:0] memAddr,
    output logic [cpuPkg::dataWidth-1:0] memWriteData,
    output logic                         memWrite,
    output logic                         memRead,
    input  logic [cpuPkg::dataWidth-1:0] memReadData
);

    logic                            stall;
    logic                            branchTaken;
    logic [cpuPkg::dataWidth-1:0]    branchTarget;
    cpuPkg::exPayloadT               exPayload;
    cpuPkg::memPayloadT              memPayload;
    cpuPkg::fwdSrcT                  exSrc;
    cpuPkg::fwdSrcT                  memSrc;
    cpuPkg::fwdSrcT                  wbSrc;
    logic                            regWrite;
    logic [cpuPkg::regAddrWidth-1:0] regWriteAddr;
    logic [cpuPkg::dataWidth-1:0]    regWriteData;

    fetchUnit fetch (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pc           (instrAddr)
    );

    decodeStage decode (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .fetchPc      (instrAddr),
        .exSrc        (exSrc),
        .memSrc       (memSrc),
        .wbSrc        (wbSrc),
        .regWrite     (regWrite),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .exOut        (exPayload)
    );

    executeStage execute (
        .clk    (clk),
        .reset  (reset),
        .exIn   (exPayload),
        .exSrc  (exSrc),
        .memOut (memPayload)
    );

    memWbStage memWb (
        .clk          (clk),
        .reset        (reset),
        .memIn        (memPayload),
        .memReadData  (memReadData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .memRead      (memRead),
        .memSrc       (memSrc),
        .wbSrc        (wbSrc),
        .regWrite     (regWrite),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData)
    );

endmodule

`default_nettype wire

/* tb/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [31:0] lcgState = 32'd91279;

function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

// Upper LCG bits are the better ones
function automatic int unsigned pick(int unsigned n);
    return (nextRandom() >> 16) % n;
endfunction

// Six registers keep dependencies dense, $0 included
function automatic logic [4:0] pickReg();
    return 5'(pick(6));
endfunction

function automatic logic [31:0] fillWord(int unsigned index);
    return (index * 32'h9E3779B1) ^ 32'h00C0FFEE;
endfunction

task automatic emit(logic [31:0] word);
    rom[romCount] = word;
    romCount++;
endtask

// Loads and stores address off $0, inside the data memory
function automatic logic [31:0] memOp(logic [5:0] op, logic [4:0] rt);
    return {op, 5'd0, rt, 16'(pick(256) * 4)};
endfunction

task automatic emitAlu(logic [4:0] src, logic [4:0] dest);
    logic [15:0] c;
    c = 16'(nextRandom() >> 16);
    case (pick(4))
        0: emit({cpuPkg::opSpecial, src, pickReg(), dest, 5'd0, cpuPkg::functAddu});
        1: emit({cpuPkg::opSpecial, src, pickReg(), dest, 5'd0, cpuPkg::functSubu});
        2: emit({cpuPkg::opOri, src, dest, c});
        default: emit({cpuPkg::opLui, 5'd0, dest, c});
    endcase
endtask

task automatic buildProgram(int unsigned segments);
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [15:0] c;
    int unsigned skip;
    for (int i = 0; i < 1024; i++) begin
        rom[i] = '0;
    end
    romCount = 0;
    repeat (segments) begin
        ra = pickReg();
        rb = pickReg();
        case (pick(5))
            // Back-to-back dependent chain
            0: begin
                repeat (3) begin
                    emitAlu(ra, rb);
                    ra = rb;
                    rb = pickReg();
                end
                emit(memOp(cpuPkg::opSw, ra));
            end
            // Load with immediate use
            1: begin
                emit(memOp(cpuPkg::opLw, ra));
                emitAlu(ra, rb);
                emit(memOp(cpuPkg::opSw, rb));
            end
            2: begin
                // Equal fresh values take the branch
                if (pick(2) == 0) begin
                    c = 16'(nextRandom() >> 16);
                    emit({cpuPkg::opOri, 5'd0, ra, c});
                    emit({cpuPkg::opOri, 5'd0, rb, c});
                end
                skip = 1 + pick(3);
                emit({cpuPkg::opBeq, ra, rb, 16'(skip + 1)});
                // Delay slot, then the skipped stores
                repeat (skip + 1) begin
                    emit(memOp(cpuPkg::opSw, pickReg()));
                end
            end
            3: begin
                emitAlu(ra, 5'd0);
                emit(memOp(cpuPkg::opSw, 5'd0));
            end
            default: begin
                emitAlu(ra, rb);
                emit(memOp(cpuPkg::opSw, pickReg()));
            end
        endcase
    end
    // Halt loop branches to itself over a nop slot
    haltPc = 32'(romCount * 4);
    emit({cpuPkg::opBeq, 10'd0, 16'hFFFF});
    emit(32'd0);
endtask

task automatic addExpected(logic isStore, logic [31:0] addr, logic [31:0] data);
    if (expCount < 1024) begin
        expected[expCount] = {isStore, addr, data};
        expCount++;
    end
endtask

task automatic runModel();
    logic [31:0] regs [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] next;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        regs[i] = 32'd0;
    end
    for (int i = 0; i < 256; i++) begin
        mem[i] = fillWord(i);
    end
    pc       = cpuPkg::resetPc;
    npc      = pc + 32'd4;
    expCount = 0;
    steps    = 0;
    while (pc != haltPc && steps < 8192) begin
        w    = rom[pc[11:2]];
        a    = regs[w[25:21]];
        b    = regs[w[20:16]];
        addr = a + {{16{w[15]}}, w[15:0]};
        next = npc + 32'd4;
        case (w[31:26])
            cpuPkg::opSpecial: begin
                if (w[5:0] == cpuPkg::functAddu) begin
                    regs[w[15:11]] = a + b;
                end else if (w[5:0] == cpuPkg::functSubu) begin
                    regs[w[15:11]] = a - b;
                end
            end
            cpuPkg::opOri: regs[w[20:16]] = a | {16'h0000, w[15:0]};
            cpuPkg::opLui: regs[w[20:16]] = {w[15:0], 16'h0000};
            cpuPkg::opLw: begin
                regs[w[20:16]] = mem[addr[9:2]];
                addExpected(1'b0, addr, 32'd0);
            end
            cpuPkg::opSw: begin
                mem[addr[9:2]] = b;
                addExpected(1'b1, addr, b);
            end
            // Offset counts from the delay slot
            cpuPkg::opBeq: begin
                if (a == b) begin
                    next = npc + {{14{w[15]}}, w[15:0], 2'b00};
                end
            end
            default: begin
            end
        endcase
        regs[0] = 32'd0;
        pc      = npc;
        npc     = next;
        steps++;
    end
endtask

`endif

/* tb/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int runCount      = 6;
    localparam int segmentCount  = 40;
    localparam int timeoutCycles = 3000;

    typedef struct packed {
        logic        isStore;
        logic [31:0] addr;
        logic [31:0] data;
    } busAccessT;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic        memWrite;
    logic        memRead;
    logic [31:0] memReadData;

    logic [31:0] rom [1024];
    logic [31:0] dmem [256];
    busAccessT   expected [1024];
    busAccessT   want;
    int unsigned romCount;
    int unsigned expCount;
    int unsigned expIdx;
    logic [31:0] haltPc;
    int unsigned valueErrors;
    int unsigned otherErrors;

    `include "cpuModel.svh"

    always #10 clk = ~clk;

    pipelineCpu UUT (
        .clk          (clk),
        .reset        (reset),
        .instrAddr    (instrAddr),
        .instr        (instr),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .memRead      (memRead),
        .memReadData  (memReadData)
    );

    assign instr       = rom[instrAddr[11:2]];
    assign memReadData = dmem[memAddr[9:2]];
    assign want        = expected[expIdx];

    // Memory reloads on every reset
    always @(posedge clk) begin
        if (reset) begin
            expIdx <= 0;
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else begin
            if (memWrite) begin
                dmem[memAddr[9:2]] <= memWriteData;
            end
            if (memWrite || memRead) begin
                expIdx <= expIdx + 1;
            end
        end
    end

    resetPcCheck: assert property (@(negedge clk) $fell(reset) |-> instrAddr == cpuPkg::resetPc)
        else begin
            valueErrors++;
            $display("ERROR instrAddr: got %h expected %h", instrAddr, cpuPkg::resetPc);
        end

    resetStrobes: assert property (@(negedge clk) $fell(reset) |-> !memWrite && !memRead)
        else begin
            otherErrors++;
            $display("A bus strobe was high right after reset");
        end

    noExtraAccess: assert property (@(negedge clk) disable iff (reset)
        (memWrite || memRead) |-> expIdx < expCount)
        else begin
            otherErrors++;
            $display("Unexpected bus access at address %h after the last expected one", memAddr);
        end

    kindMatches: assert property (@(negedge clk) disable iff (reset)
        (memWrite || memRead) && expIdx < expCount |-> memWrite == want.isStore)
        else begin
            valueErrors++;
            $display("ERROR memWrite: got %h expected %h", memWrite, want.isStore);
        end

    addrMatches: assert property (@(negedge clk) disable iff (reset)
        (memWrite || memRead) && expIdx < expCount |-> memAddr == want.addr)
        else begin
            valueErrors++;
            $display("ERROR memAddr: got %h expected %h", memAddr, want.addr);
        end

    dataMatches: assert property (@(negedge clk) disable iff (reset)
        memWrite && expIdx < expCount && want.isStore |-> memWriteData == want.data)
        else begin
            valueErrors++;
            $display("ERROR memWriteData: got %h expected %h", memWriteData, want.data);
        end

    strobesExclusive: assert property (@(negedge clk) disable iff (reset)
        !(memWrite && memRead))
        else begin
            otherErrors++;
            $display("memWrite and memRead were high in the same cycle");
        end

    initial begin
        int unsigned waited;
        logic        timedOut;
        reset       = 1'b1;
        valueErrors = 0;
        otherErrors = 0;
        romCount    = 0;
        expCount    = 0;
        haltPc      = '0;
        timedOut    = 1'b0;
        for (int run = 0; run < runCount && !timedOut; run++) begin
            buildProgram(segmentCount);
            runModel();
            repeat (8) begin
                @(posedge clk);
            end
            #1;
            reset  = 1'b0;
            waited = 0;
            while (expIdx < expCount && waited < timeoutCycles) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (expIdx < expCount) begin
                otherErrors++;
                timedOut = 1'b1;
                $display("Run %0d timed out after %0d of %0d bus accesses",
                         run, expIdx, expCount);
            end
            // Anything still in flight leaves the pipeline here
            repeat (4) begin
                @(posedge clk);
            end
            #1;
            reset = 1'b1;
        end
        $display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pipelineCpu.f */
+incdir+tb
design/cpuPkg.sv
design/registerFile.sv
design/operandForward.sv
design/fetchUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/pipelineCpu.sv
tb/cpuTb.sv

/* Bender.yml */
package:
  name: pipeline_cpu

sources:
  - design/cpuPkg.sv
  - design/registerFile.sv
  - design/operandForward.sv
  - design/fetchUnit.sv
  - design/decodeStage.sv
  - design/executeStage.sv
  - design/memWbStage.sv
  - design/pipelineCpu.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/cpuTb.sv
